/* dv/uart_aes_stim.txt */
# header key data result, all hex, one command per line
# key and data go out low byte first, result is what the AES stand-in returns
01 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
03 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
00 0123456789abcdeffedcba9876543210 deadbeefcafef00d8badf00d01234567 13579bdf02468acefdb97531eca86420
02 80000000000000000000000000000001 7fffffffffffffffffffffffffffffff 00000001000000020000000300000004
81 c3c3c3c33c3c3c3c96969696e1e1e1e1 55aa55aa33cc33cc0ff00ff0a5a55a5a 3c4fcf098815f7aba6d2ae2816157e2b
00 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 66e94bd4ef8a2c3b884cfa59ca342b2e
01 10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465

/* uart_aes_ctrl.f */
common/uart_aes_pkg.sv
uart_rx/uart_rx.sv
verilog/aes_cmd_frame.sv
uart_tx/uart_tx.sv
verilog/uart_aes_ctrl.sv
dv/uart_aes_checker.sv
dv/tb_uart_aes_ctrl.sv

/* Makefile */
TOP = tb_uart_aes_ctrl

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -j 0 --top-module $(TOP) -f uart_aes_ctrl.f -o sim
	./obj_dir/sim | awk '{ print } /^Done: no errors$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f uart_aes_ctrl.f

clean:
	rm -rf obj_dir

/* dv/tb_uart_aes_ctrl.sv */
`timescale 1ns/1ns

module tb_uart_aes_ctrl;

  localparam int CLKS_PER_BIT = 16;
  localparam int MAX_LINES = 64;

  logic                 CLK;
  logic                 NRST;
  logic                 rx_uart;
  uart_aes_pkg::block_t dout_aes;
  logic                 dvld_aes;
  logic                 tx_uart;
  logic                 en_aes;
  logic                 rstn_aes;
  uart_aes_pkg::block_t kin_aes;
  uart_aes_pkg::block_t din_aes;
  logic                 kdrdy_aes;

  // One entry per command line of the stimulus file
  uart_aes_pkg::byte_t  hdr_mem [MAX_LINES];
  uart_aes_pkg::block_t key_mem [MAX_LINES];
  uart_aes_pkg::block_t data_mem [MAX_LINES];
  uart_aes_pkg::block_t res_mem [MAX_LINES];

  uart_aes_pkg::byte_t  cur_hdr;
  uart_aes_pkg::block_t cur_key;
  uart_aes_pkg::block_t cur_data;
  uart_aes_pkg::block_t cur_res;
  logic [5:0]           sent_cnt;  // Bytes of this command fully on the line
  int                   n_lines;
  int                   cycle_cnt;
  int                   cycle_limit;
  int                   err_cnt;
  int                   check_cnt;
  int                   cmd_cnt;
  int                   reply_cnt;

  uart_aes_ctrl #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_dut (
    .CLK(CLK), .NRST(NRST), .rx_uart(rx_uart), .dout_aes(dout_aes), .dvld_aes(dvld_aes),
    .tx_uart(tx_uart), .en_aes(en_aes), .rstn_aes(rstn_aes), .kin_aes(kin_aes),
    .din_aes(din_aes), .kdrdy_aes(kdrdy_aes)
  );

  uart_aes_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_checker (
    .CLK(CLK), .NRST(NRST), .tx_uart(tx_uart), .rstn_aes(rstn_aes), .en_aes(en_aes),
    .kin_aes(kin_aes), .din_aes(din_aes), .kdrdy_aes(kdrdy_aes), .dvld_aes(dvld_aes),
    .exp_hdr(cur_hdr), .exp_key(cur_key), .exp_data(cur_data), .exp_res(cur_res),
    .sent_cnt(sent_cnt), .err_cnt(err_cnt), .check_cnt(check_cnt), .cmd_cnt(cmd_cnt),
    .reply_cnt(reply_cnt)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic send_byte(input uart_aes_pkg::byte_t value);
    int bit_i;
    repeat ($urandom % 41) @(posedge CLK);  // Idle gap
    rx_uart <= 1'b0;
    repeat (CLKS_PER_BIT) @(posedge CLK);
    for (bit_i = 0; bit_i < 8; bit_i++) begin
      rx_uart <= value[bit_i];  // LSB first
      repeat (CLKS_PER_BIT) @(posedge CLK);
    end
    rx_uart <= 1'b1;
    repeat (CLKS_PER_BIT) @(posedge CLK);
    sent_cnt <= sent_cnt + 6'd1;
  endtask

  // Low pulse well under half a bit
  task automatic send_glitch();
    rx_uart <= 1'b0;
    repeat (CLKS_PER_BIT / 4) @(posedge CLK);
    rx_uart <= 1'b1;
    repeat (2 * CLKS_PER_BIT) @(posedge CLK);
  endtask

  task automatic run_command(input int li);
    int bi;
    cur_hdr  <= hdr_mem[li];
    cur_key  <= key_mem[li];
    cur_data <= data_mem[li];
    cur_res  <= res_mem[li];
    sent_cnt <= '0;
    send_glitch();
    send_byte(hdr_mem[li]);
    for (bi = 0; bi < uart_aes_pkg::BLOCK_BYTES; bi++) send_byte(key_mem[li][8*bi +: 8]);
    for (bi = 0; bi < uart_aes_pkg::BLOCK_BYTES; bi++) send_byte(data_mem[li][8*bi +: 8]);
    // AES core stand-in answers right after key and data are ready
    do @(posedge CLK); while (kdrdy_aes !== 1'b1);
    dout_aes <= res_mem[li];
    dvld_aes <= 1'b1;
    @(posedge CLK);
    dvld_aes <= 1'b0;
  endtask

  initial begin : main_flow
    int                   fd;
    int                   rd_cnt;
    int                   li;
    string                line;
    uart_aes_pkg::byte_t  h;
    uart_aes_pkg::block_t k;
    uart_aes_pkg::block_t d;
    uart_aes_pkg::block_t r;
    NRST = 1'b0;
    rx_uart = 1'b1;
    dout_aes = '0;
    dvld_aes = 1'b0;
    sent_cnt = '0;
    cur_hdr = '0;
    cur_key = '0;
    cur_data = '0;
    cur_res = '0;
    n_lines = 0;
    cycle_limit = 0;
    void'($urandom(28673));
    fd = $fopen("dv/uart_aes_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/uart_aes_stim.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        rd_cnt = $fgets(line, fd);
        if (rd_cnt > 0 && line.getc(0) != "#") begin
          rd_cnt = $sscanf(line, "%h %h %h %h", h, k, d, r);
          if (rd_cnt == 4) begin
            hdr_mem[n_lines] = h;
            key_mem[n_lines] = k;
            data_mem[n_lines] = d;
            res_mem[n_lines] = r;
            n_lines++;
          end
        end
      end
      $fclose(fd);
      cycle_limit = 12000 * n_lines + 1000;
      repeat (8) @(posedge CLK);
      NRST <= 1'b1;
      repeat (4) @(posedge CLK);
      for (li = 0; li < n_lines; li++) run_command(li);
      while (reply_cnt < n_lines) @(posedge CLK);
      repeat (CLKS_PER_BIT) @(posedge CLK);
      if (n_lines == 0) $display("Stimulus file holds no commands");
      $display("Checks: %0d  errors: %0d  commands: %0d  replies: %0d",
               check_cnt, err_cnt, cmd_cnt, reply_cnt);
      if (err_cnt == 0 && n_lines > 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout: run still busy after %0d cycles", cycle_limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* dv/uart_aes_checker.sv */
`timescale 1ns/1ns

module uart_aes_checker #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                 CLK,
  input  logic                 NRST,
  input  logic                 tx_uart,
  input  logic                 rstn_aes,
  input  logic                 en_aes,
  input  uart_aes_pkg::block_t kin_aes,
  input  uart_aes_pkg::block_t din_aes,
  input  logic                 kdrdy_aes,
  input  logic                 dvld_aes,
  input  uart_aes_pkg::byte_t  exp_hdr,
  input  uart_aes_pkg::block_t exp_key,
  input  uart_aes_pkg::block_t exp_data,
  input  uart_aes_pkg::block_t exp_res,
  input  logic [5:0]           sent_cnt,
  output int                   err_cnt,
  output int                   check_cnt,
  output int                   cmd_cnt,
  output int                   reply_cnt
);

  localparam int MAX_REPLIES = 64;

  uart_aes_pkg::block_t res_mem [MAX_REPLIES];  // Results handed to the DUT, in order
  int         res_wr = 0;
  int         mon_errs = 0;
  int         mon_checks = 0;
  int         tx_errs = 0;
  int         tx_checks = 0;
  int         done_cmds = 0;
  int         done_replies = 0;
  logic [5:0] sent_prev = '0;
  logic       rst_seen = 1'b0;
  logic       en_seen = 1'b0;

  assign err_cnt   = mon_errs + tx_errs;
  assign check_cnt = mon_checks + tx_checks;
  assign cmd_cnt   = done_cmds;
  assign reply_cnt = done_replies;

  task automatic report_mismatch(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  always @(posedge CLK) begin : port_monitor
    int   done_bytes;
    logic exp_rstn;
    logic exp_en;
    if (!NRST) begin
      if (rst_seen) begin
        mon_checks++;
        if (tx_uart !== 1'b1 || rstn_aes !== 1'b0 || en_aes !== 1'b0 ||
            kdrdy_aes !== 1'b0 || kin_aes !== '0 || din_aes !== '0) begin
          mon_errs++;
          report_mismatch("outputs not at their reset values while NRST is low");
        end
      end
      rst_seen = 1'b1;
    end else begin
      // Byte boundary, the DUT has taken all bytes but the one just finished
      if (sent_cnt != sent_prev && sent_cnt != 6'd0) begin
        done_bytes = int'(sent_cnt) - 1;
        exp_rstn   = !(done_bytes == 1 && exp_hdr[uart_aes_pkg::HDR_RST_BIT]);
        exp_en     = done_cmds > 0 || done_bytes >= uart_aes_pkg::EN_AT_BYTE;
        mon_checks++;
        if (rstn_aes !== exp_rstn) begin
          mon_errs++;
          report_mismatch($sformatf("rstn_aes %b after %0d bytes, expected %b",
                                    rstn_aes, done_bytes, exp_rstn));
        end
        if (en_aes !== exp_en) begin
          mon_errs++;
          report_mismatch($sformatf("en_aes %b after %0d bytes, expected %b",
                                    en_aes, done_bytes, exp_en));
        end
      end
      if (en_aes === 1'b1) begin
        en_seen = 1'b1;
      end else if (en_seen) begin
        mon_errs++;
        report_mismatch("en_aes dropped after going high");
        en_seen = 1'b0;  // One report per drop
      end
      if (kdrdy_aes === 1'b1) begin
        mon_checks++;
        if (sent_cnt != 6'(uart_aes_pkg::CMD_BYTES)) begin
          mon_errs++;
          report_mismatch($sformatf("kdrdy_aes after %0d bytes", sent_cnt));
        end
        if (kin_aes !== exp_key) begin
          mon_errs++;
          report_mismatch($sformatf("kin_aes %h, expected %h", kin_aes, exp_key));
        end
        if (din_aes !== exp_data) begin
          mon_errs++;
          report_mismatch($sformatf("din_aes %h, expected %h", din_aes, exp_data));
        end
        done_cmds++;
      end
      if (dvld_aes === 1'b1 && res_wr < MAX_REPLIES) begin
        res_mem[res_wr] = exp_res;
        res_wr++;
      end
    end
    sent_prev = sent_cnt;
  end

  // Serial decoder for tx_uart, samples every bit at its middle
  initial begin : tx_decode
    uart_aes_pkg::byte_t got_byte;
    int                  bit_i;
    int                  byte_i;
    byte_i = 0;
    wait (NRST === 1'b1);
    forever begin
      @(posedge CLK);
      if (tx_uart === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(posedge CLK);
        tx_checks++;
        if (tx_uart !== 1'b0) begin
          tx_errs++;
          report_mismatch("tx_uart start bit not low at mid-bit");
        end
        for (bit_i = 0; bit_i < 8; bit_i++) begin
          repeat (CLKS_PER_BIT) @(posedge CLK);
          got_byte[bit_i] = tx_uart;
        end
        repeat (CLKS_PER_BIT) @(posedge CLK);
        if (tx_uart !== 1'b1) begin
          tx_errs++;
          report_mismatch($sformatf("tx_uart stop bit missing after byte %0d", byte_i));
        end
        if (done_replies >= res_wr) begin
          tx_errs++;
          $display("tx_uart sent a byte while no AES result was pending");
        end else if (got_byte !== res_mem[done_replies][8*byte_i +: 8]) begin
          tx_errs++;
          report_mismatch($sformatf("reply %0d byte %0d is %h, expected %h", done_replies,
                                    byte_i, got_byte, res_mem[done_replies][8*byte_i +: 8]));
        end
        byte_i++;
        if (byte_i == uart_aes_pkg::BLOCK_BYTES) begin
          byte_i = 0;
          done_replies++;
        end
      end
    end
  end

endmodule

/* verilog/uart_aes_ctrl.sv */
`timescale 1ns/1ns

module uart_aes_ctrl #(
  parameter int CLKS_PER_BIT = 10416  // 100 MHz clock, 9600 baud
) (
  input  logic                 CLK,
  input  logic                 NRST,
  input  logic                 rx_uart,
  input  uart_aes_pkg::block_t dout_aes,
  input  logic                 dvld_aes,
  output logic                 tx_uart,
  output logic                 en_aes,
  output logic                 rstn_aes,
  output uart_aes_pkg::block_t kin_aes,
  output uart_aes_pkg::block_t din_aes,
  output logic                 kdrdy_aes
);

  uart_aes_pkg::byte_t rx_byte;
  logic                rx_valid;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_uart_rx (
    .CLK      (CLK),
    .NRST     (NRST),
    .rx_uart  (rx_uart),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  // Command bytes straight into the AES control outputs
  aes_cmd_frame i_aes_cmd_frame (
    .CLK       (CLK),
    .NRST      (NRST),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rstn_aes  (rstn_aes),
    .en_aes    (en_aes),
    .kin_aes   (kin_aes),
    .din_aes   (din_aes),
    .kdrdy_aes (kdrdy_aes)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_uart_tx (
    .CLK      (CLK),
    .NRST     (NRST),
    .dout_aes (dout_aes),
    .dvld_aes (dvld_aes),
    .tx_uart  (tx_uart)
  );

endmodule

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
  parameter int CLKS_PER_BIT = 10416
) (
  input  logic                 CLK,
  input  logic                 NRST,
  input  uart_aes_pkg::block_t dout_aes,
  input  logic                 dvld_aes,
  output logic                 tx_uart
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BYTE_W = $clog2(uart_aes_pkg::BLOCK_BYTES);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(uart_aes_pkg::BLOCK_BYTES - 1);

  uart_aes_pkg::tx_state_e state;
  logic [CNT_W-1:0]        clk_cnt;
  logic [2:0]              bit_idx;
  logic [BYTE_W-1:0]       byte_idx;
  uart_aes_pkg::block_t    tx_shift;  // Current byte always sits in bits 7:0

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state    <= uart_aes_pkg::TX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      byte_idx <= '0;
      tx_uart  <= 1'b1;
    end else begin
      case (state)
        uart_aes_pkg::TX_IDLE: begin
          if (dvld_aes) begin
            state    <= uart_aes_pkg::TX_START;
            clk_cnt  <= '0;
            byte_idx <= '0;
            tx_uart  <= 1'b0;
          end
        end
        uart_aes_pkg::TX_START: begin
          if (clk_cnt == BIT_END) begin
            state   <= uart_aes_pkg::TX_DATA;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_uart <= tx_shift[0];
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_aes_pkg::TX_DATA: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state   <= uart_aes_pkg::TX_STOP;
              tx_uart <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_uart <= tx_shift[1];  // Bit 0 leaves with this shift
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_aes_pkg::TX_STOP: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            if (byte_idx == LAST_BYTE) begin
              state <= uart_aes_pkg::TX_IDLE;
            end else begin
              state    <= uart_aes_pkg::TX_START;
              byte_idx <= byte_idx + 1'b1;
              tx_uart  <= 1'b0;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Eight shifts per byte, last one as the stop bit starts
  always_ff @(posedge CLK) begin
    if (state == uart_aes_pkg::TX_IDLE && dvld_aes) begin
      tx_shift <= dout_aes;
    end else if (state == uart_aes_pkg::TX_DATA && clk_cnt == BIT_END) begin
      tx_shift <= {1'b0, tx_shift[127:1]};
    end
  end

  // Core must not finish a new block before the previous reply is out
  a_dvld_idle: assert property (
    @(posedge CLK) disable iff (!NRST) dvld_aes |-> state == uart_aes_pkg::TX_IDLE
  ) else $error("dvld_aes during transmission, result dropped");

endmodule

/* verilog/aes_cmd_frame.sv */
`timescale 1ns/1ns

module aes_cmd_frame (
  input  logic                 CLK,
  input  logic                 NRST,
  input  uart_aes_pkg::byte_t  rx_byte,
  input  logic                 rx_valid,
  output logic                 rstn_aes,
  output logic                 en_aes,
  output uart_aes_pkg::block_t kin_aes,
  output uart_aes_pkg::block_t din_aes,
  output logic                 kdrdy_aes
);

  localparam int CNT_W = $clog2(uart_aes_pkg::CMD_BYTES + 1);
  localparam int LANE_W = $clog2(uart_aes_pkg::BLOCK_BYTES);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(uart_aes_pkg::CMD_BYTES);
  localparam logic [CNT_W-1:0] KEY_END = CNT_W'(uart_aes_pkg::BLOCK_BYTES);
  localparam logic [CNT_W-1:0] DATA_END = CNT_W'(2 * uart_aes_pkg::BLOCK_BYTES);

  logic [CNT_W-1:0]    byte_cnt;   // Bytes received in this frame
  logic [CNT_W-1:0]    byte_idx;
  logic [LANE_W-1:0]   lane;
  logic                key_wr;
  logic                data_wr;
  uart_aes_pkg::byte_t hdr_reg;

  // Index past the header, wraps to all ones while byte_cnt is 0
  assign byte_idx = byte_cnt - 1'b1;
  assign lane     = byte_idx[LANE_W-1:0];  // Same lane for key and data bytes
  assign key_wr   = rx_valid && byte_idx < KEY_END;
  assign data_wr  = rx_valid && byte_idx >= KEY_END && byte_idx < DATA_END;

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      byte_cnt <= '0;
    end else if (byte_cnt == LAST_CNT) begin
      byte_cnt <= '0;  // Frame done, kdrdy_aes is high this cycle
    end else if (rx_valid) begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_valid && byte_cnt == '0) begin
      hdr_reg <= rx_byte;
    end
  end

  // First byte of each block ends up in bits 7:0
  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      kin_aes <= '0;
      din_aes <= '0;
    end else begin
      if (key_wr) begin
        kin_aes[{lane, 3'b000} +: 8] <= rx_byte;
      end
      if (data_wr) begin
        din_aes[{lane, 3'b000} +: 8] <= rx_byte;
      end
    end
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      rstn_aes  <= 1'b0;
      en_aes    <= 1'b0;
      kdrdy_aes <= 1'b0;
    end else begin
      // Core reset spans the gap between header and first key byte
      if (rx_valid && byte_cnt == '0) begin
        rstn_aes <= !rx_byte[uart_aes_pkg::HDR_RST_BIT];
      end else if (!rx_valid && byte_cnt == CNT_W'(1)) begin
        rstn_aes <= !hdr_reg[uart_aes_pkg::HDR_RST_BIT];
      end else begin
        rstn_aes <= 1'b1;
      end

      if (rx_valid && byte_cnt == CNT_W'(uart_aes_pkg::EN_AT_BYTE - 1)) begin
        en_aes <= 1'b1;  // Sticky until NRST
      end

      kdrdy_aes <= rx_valid && byte_cnt == LAST_CNT - 1'b1;
    end
  end

  a_cnt_range: assert property (
    @(posedge CLK) disable iff (!NRST) byte_cnt == LAST_CNT |-> !rx_valid
  ) else $error("command byte arrived past end of frame");

endmodule

/* uart_rx/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLKS_PER_BIT = 10416
) (
  input  logic                CLK,
  input  logic                NRST,
  input  logic                rx_uart,
  output uart_aes_pkg::byte_t rx_byte,
  output logic                rx_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] BIT_MID = CNT_W'(CLKS_PER_BIT / 2);

  uart_aes_pkg::rx_state_e state;
  logic [CNT_W-1:0]        clk_cnt;   // Cycle within current bit
  logic [2:0]              bit_idx;
  logic                    rx_meta;
  logic                    rx_sync;
  uart_aes_pkg::byte_t     rx_shift;

  // Line idles high, so the flops come out of reset high too
  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_uart;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state    <= uart_aes_pkg::RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        uart_aes_pkg::RX_IDLE: begin
          if (!rx_sync) begin
            state   <= uart_aes_pkg::RX_START;
            clk_cnt <= CNT_W'(1);  // Edge cycle is already part of the start bit
          end
        end
        uart_aes_pkg::RX_START: begin
          if (clk_cnt == BIT_MID && rx_sync) begin
            state <= uart_aes_pkg::RX_IDLE;  // Glitch, not a start bit
          end else if (clk_cnt == BIT_END) begin
            state   <= uart_aes_pkg::RX_DATA;
            clk_cnt <= '0;
            bit_idx <= '0;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_aes_pkg::RX_DATA: begin
          if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= uart_aes_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_aes_pkg::RX_STOP: begin
          // Stop bit level is not checked
          if (clk_cnt == BIT_END) begin
            state    <= uart_aes_pkg::RX_IDLE;
            clk_cnt  <= '0;
            rx_valid <= 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge CLK) begin
    if (state == uart_aes_pkg::RX_DATA && clk_cnt == BIT_MID) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
  end

  assign rx_byte = rx_shift;

  // A frame is ten bit periods long, so strobes can never be adjacent
  a_valid_single: assert property (
    @(posedge CLK) disable iff (!NRST) rx_valid |=> !rx_valid
  ) else $error("rx_valid held for more than one cycle");

endmodule

/* common/uart_aes_pkg.sv */
package uart_aes_pkg;

  // One byte on the serial line
  typedef logic [7:0] byte_t;

  // AES key, plaintext or ciphertext
  typedef logic [127:0] block_t;

  localparam int BLOCK_BYTES = 16;

  // Header byte, then key bytes, then data bytes
  localparam int CMD_BYTES = 1 + 2 * BLOCK_BYTES;

  localparam int EN_AT_BYTE = 30;   // Core enable turns on late in the first frame
  localparam int HDR_RST_BIT = 0;   // Header bit asking for an AES reset

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage
